//--- verilog/immu_pkg.sv
package immu_pkg;

  ////////////////////
  // Widths

  // Data and address width of the core
  localparam int OPERAND_WIDTH = 32;
  // 8 KB pages
  localparam int PAGE_BITS = 13;
  localparam int VPN_WIDTH = OPERAND_WIDTH - PAGE_BITS;
  // Address bits passed through untranslated on a miss
  localparam int MISS_ADDR_BITS = 24;

  ////////////////////
  // SPR address decode

  localparam int SPR_ADDR_WIDTH = 16;
  // Group number sits in the top bits of the SPR address
  localparam int SPR_GROUP_WIDTH = 5;
  localparam logic [SPR_GROUP_WIDTH-1:0] SPR_GROUP_IMMU = 5'd2;
  // Bits 10:9 nonzero marks the TLB region
  localparam int SPR_TLB_LSB = 9;
  // Set selects translate RAM, clear selects match RAM
  localparam int SPR_TRANS_SEL_BIT = 7;

  ////////////////////
  // Entry fields

  // Match entry, VPN in the upper bits
  localparam int MATCH_VALID_BIT = 0;
  // Translate entry, PPN in the upper bits
  localparam int TRANS_CI_BIT = 1;
  localparam int TRANS_SXE_BIT = 6;
  localparam int TRANS_UXE_BIT = 7;

  typedef logic [OPERAND_WIDTH-1:0]  word_t;
  typedef logic [VPN_WIDTH-1:0]      vpn_t;
  typedef logic [SPR_ADDR_WIDTH-1:0] spr_addr_t;

  // SPR bus request, 50 bits
  typedef struct packed {
    logic      stb;
    logic      we;
    spr_addr_t addr;
    word_t     dat;
  } spr_req_t;

  // RAM write, address travels separately
  typedef struct packed {
    logic  we;
    word_t dat;
  } ram_wr_t;

endpackage

//--- verilog/itlb_ram.sv
`timescale 1ns/1ps

module itlb_ram
  import immu_pkg::*;
#(
  parameter int SET_WIDTH = 6
) (
  input  logic                 clk,

  // Shared address for read and write
  input  logic [SET_WIDTH-1:0] addr_i,
  input  ram_wr_t              wr_i,

  // Registered read data
  output word_t                dout_o
);

  localparam int DEPTH = 2 ** SET_WIDTH;

  // One entry per set
  word_t mem [DEPTH];

  ////////////////////
  // Write port

  always_ff @(posedge clk) begin
    if (wr_i.we) begin
      mem[addr_i] <= wr_i.dat;
    end
  end

  ////////////////////
  // Read port

  // Old contents come out on a write to the same set
  always_ff @(posedge clk) begin
    dout_o <= mem[addr_i];
  end

endmodule

//--- verilog/itlb_spr_port.sv
`timescale 1ns/1ps

module itlb_spr_port
  import immu_pkg::*;
#(
  parameter int SET_WIDTH = 6
) (
  input  logic                 clk,
  input  logic                 rst,

  // SPR bus request
  input  spr_req_t             spr_i,
  input  logic                 enable_i,

  // RAM read data, one cycle after addressing
  input  word_t                match_dout_i,
  input  word_t                trans_dout_i,

  // RAM write control
  output ram_wr_t              match_wr_o,
  output ram_wr_t              trans_wr_o,
  output logic                 spr_owns_port_o,
  output logic [SET_WIDTH-1:0] spr_set_o,

  output logic                 busy_o,
  output logic                 ack_o,
  output word_t                dat_o
);

  logic  group_sel;
  logic  tlb_region;
  logic  match_cs;
  logic  trans_cs;
  logic  match_cs_r;
  logic  trans_cs_r;
  logic  ack_q;
  logic  ack_r;
  logic  first_ack;
  word_t rd_dat;
  word_t rd_dat_q;

  ////////////////////
  // Address decode

  // Group 2 at the top of the address
  assign group_sel = spr_i.stb &
                     (spr_i.addr[SPR_ADDR_WIDTH-1 -: SPR_GROUP_WIDTH] == SPR_GROUP_IMMU);
  assign tlb_region = |spr_i.addr[SPR_TLB_LSB +: 2];

  // Bit 7 picks translate over match
  assign match_cs = group_sel & tlb_region & !spr_i.addr[SPR_TRANS_SEL_BIT];
  assign trans_cs = group_sel & tlb_region & spr_i.addr[SPR_TRANS_SEL_BIT];

  assign spr_set_o = spr_i.addr[SET_WIDTH-1:0];

  ////////////////////
  // Ack and select registers

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_q      <= 1'b0;
      ack_r      <= 1'b0;
      match_cs_r <= 1'b0;
      trans_cs_r <= 1'b0;
    end else begin
      ack_q      <= group_sel;
      ack_r      <= ack_q;
      match_cs_r <= match_cs;
      trans_cs_r <= trans_cs;
    end
  end

  // Dropped together with stb
  assign ack_o = ack_q & group_sel;
  assign first_ack = ack_q & !ack_r;

  ////////////////////
  // RAM write control

  // Port taken over in the pre-ack cycle only
  assign spr_owns_port_o = (match_cs | trans_cs) & !ack_q;

  assign match_wr_o.we  = match_cs & spr_i.we & !ack_q;
  assign match_wr_o.dat = spr_i.dat;
  assign trans_wr_o.we  = trans_cs & spr_i.we & !ack_q;
  assign trans_wr_o.dat = spr_i.dat;

  ////////////////////
  // Read data

  // Non-TLB registers of the group read as zero
  assign rd_dat = match_cs_r ? match_dout_i :
                  trans_cs_r ? trans_dout_i : '0;

  // RAM output moves on after the first ack cycle
  always_ff @(posedge clk) begin
    if (first_ack) begin
      rd_dat_q <= rd_dat;
    end
  end

  assign dat_o = first_ack ? rd_dat : rd_dat_q;

  // Lookup results invalid while SPR access holds the port
  // or its read data is still on the RAM outputs
  assign busy_o = enable_i &
                  ((match_cs | trans_cs) & !ack_q |
                   (match_cs_r | trans_cs_r) & first_ack);

endmodule

//--- verilog/itlb_lookup.sv
`timescale 1ns/1ps

module itlb_lookup
  import immu_pkg::*;
(
  // Address being translated, index applied a cycle earlier
  input  word_t virt_addr_match_i,

  // Entries read from the RAMs
  input  word_t match_dout_i,
  input  word_t trans_dout_i,

  input  logic  supervisor_mode_i,
  input  logic  busy_i,

  output word_t phys_addr_o,
  output logic  cache_inhibit_o,
  output logic  tlb_miss_o,
  output logic  pagefault_o
);

  vpn_t addr_vpn;
  vpn_t entry_vpn;
  logic hit;
  // Execute enables per mode
  logic sxe;
  logic uxe;

  ////////////////////
  // Tag compare

  assign addr_vpn  = virt_addr_match_i[OPERAND_WIDTH-1:PAGE_BITS];
  assign entry_vpn = match_dout_i[OPERAND_WIDTH-1:PAGE_BITS];

  assign hit = match_dout_i[MATCH_VALID_BIT] & (entry_vpn == addr_vpn);

  ////////////////////
  // Translation

  always_comb begin
    // Miss passes the low address bits through
    phys_addr_o = '0;
    phys_addr_o[MISS_ADDR_BITS-1:0] = virt_addr_match_i[MISS_ADDR_BITS-1:0];
    cache_inhibit_o = 1'b0;
    sxe = 1'b0;
    uxe = 1'b0;

    if (hit) begin
      // PPN joined to page offset
      phys_addr_o = {trans_dout_i[OPERAND_WIDTH-1:PAGE_BITS],
                     virt_addr_match_i[PAGE_BITS-1:0]};
      cache_inhibit_o = trans_dout_i[TRANS_CI_BIT];
      sxe = trans_dout_i[TRANS_SXE_BIT];
      uxe = trans_dout_i[TRANS_UXE_BIT];
    end
  end

  ////////////////////
  // Miss and fault

  // Both held off while SPR access owns the RAMs
  assign tlb_miss_o = !hit & !busy_i;

  // A miss has no execute rights, so it faults too
  assign pagefault_o = (supervisor_mode_i ? !sxe : !uxe) & !busy_i;

endmodule

//--- verilog/or1k_immu.sv
`timescale 1ns/1ps

module or1k_immu
  import immu_pkg::*;
#(
  parameter int SET_WIDTH = 6
) (
  input  logic      clk,
  input  logic      rst,

  input  logic      enable_i,
  output logic      busy_o,

  // Fetch side
  input  word_t     virt_addr_i,
  input  word_t     virt_addr_match_i,
  output word_t     phys_addr_o,
  output logic      cache_inhibit_o,

  input  logic      supervisor_mode_i,

  output logic      tlb_miss_o,
  output logic      pagefault_o,

  // SPR bus
  input  spr_addr_t spr_bus_addr_i,
  input  logic      spr_bus_we_i,
  input  logic      spr_bus_stb_i,
  input  word_t     spr_bus_dat_i,

  output word_t     spr_bus_dat_o,
  output logic      spr_bus_ack_o
);

  spr_req_t             spr_req;
  ram_wr_t              match_wr;
  ram_wr_t              trans_wr;
  word_t                match_dout;
  word_t                trans_dout;
  logic                 spr_owns_port;
  logic [SET_WIDTH-1:0] spr_set;
  logic [SET_WIDTH-1:0] fetch_set;
  logic [SET_WIDTH-1:0] ram_addr;

  assign spr_req = '{stb: spr_bus_stb_i, we: spr_bus_we_i,
                     addr: spr_bus_addr_i, dat: spr_bus_dat_i};

  ////////////////////
  // RAM address mux

  // Index from the next fetch address, just above the page offset
  assign fetch_set = virt_addr_i[PAGE_BITS +: SET_WIDTH];
  assign ram_addr  = spr_owns_port ? spr_set : fetch_set;

  itlb_ram #(
    .SET_WIDTH (SET_WIDTH)
  ) match_ram (
    .clk    (clk),
    .addr_i (ram_addr),
    .wr_i   (match_wr),
    .dout_o (match_dout)
  );

  itlb_ram #(
    .SET_WIDTH (SET_WIDTH)
  ) trans_ram (
    .clk    (clk),
    .addr_i (ram_addr),
    .wr_i   (trans_wr),
    .dout_o (trans_dout)
  );

  itlb_spr_port #(
    .SET_WIDTH (SET_WIDTH)
  ) spr_port (
    .clk             (clk),
    .rst             (rst),
    .spr_i           (spr_req),
    .enable_i        (enable_i),
    .match_dout_i    (match_dout),
    .trans_dout_i    (trans_dout),
    .match_wr_o      (match_wr),
    .trans_wr_o      (trans_wr),
    .spr_owns_port_o (spr_owns_port),
    .spr_set_o       (spr_set),
    .busy_o          (busy_o),
    .ack_o           (spr_bus_ack_o),
    .dat_o           (spr_bus_dat_o)
  );

  itlb_lookup lookup (
    .virt_addr_match_i (virt_addr_match_i),
    .match_dout_i      (match_dout),
    .trans_dout_i      (trans_dout),
    .supervisor_mode_i (supervisor_mode_i),
    .busy_i            (busy_o),
    .phys_addr_o       (phys_addr_o),
    .cache_inhibit_o   (cache_inhibit_o),
    .tlb_miss_o        (tlb_miss_o),
    .pagefault_o       (pagefault_o)
  );

endmodule

//--- tb/or1k_immu_sva.sv
`timescale 1ns/1ps

module or1k_immu_sva
  import immu_pkg::*;
#(
  parameter int SET_WIDTH = 6
) (
  input logic      clk,
  input logic      rst,
  input logic      enable_i,
  input logic      busy_o,
  input word_t     virt_addr_match_i,
  input word_t     phys_addr_o,
  input logic      cache_inhibit_o,
  input logic      supervisor_mode_i,
  input logic      tlb_miss_o,
  input logic      pagefault_o,
  input spr_addr_t spr_bus_addr_i,
  input logic      spr_bus_we_i,
  input logic      spr_bus_stb_i,
  input word_t     spr_bus_dat_i,
  input word_t     spr_bus_dat_o,
  input logic      spr_bus_ack_o
);

  // Shadow of the entries as seen on the SPR bus
  word_t match_sh [2**SET_WIDTH];
  word_t trans_sh [2**SET_WIDTH];
  // Read by the testbench at the end of the run
  int unsigned err_count = 0;

  logic                   stb_q;
  logic                   rise_q;
  logic                   grp;
  logic                   tlb;
  logic [SET_WIDTH-1:0]   spr_set;
  logic [SET_WIDTH-1:0]   fetch_set;
  word_t                  rd_exp;
  word_t                  m_ent;
  word_t                  t_ent;
  logic                   hit;
  logic                   busy_exp;
  logic                   chk;
  logic [OPERAND_WIDTH+2:0] look;
  logic [OPERAND_WIDTH+2:0] look_exp;

  function automatic void count_failure(input string msg);
    err_count++;
    $error("%s", msg);
  endfunction

  ////////////////////
  // SPR side model

  // Group 2 in the top five address bits
  assign grp = spr_bus_stb_i && (spr_bus_addr_i[15:11] == SPR_GROUP_IMMU);
  assign tlb = grp && (spr_bus_addr_i[10:9] != 2'b00);
  assign spr_set = spr_bus_addr_i[SET_WIDTH-1:0];
  // Bit 7 set reads the translate word
  assign rd_exp = spr_bus_addr_i[7] ? trans_sh[spr_set] : match_sh[spr_set];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      stb_q  <= 1'b0;
      rise_q <= 1'b0;
    end else begin
      stb_q  <= spr_bus_stb_i;
      rise_q <= tlb && !stb_q;
    end
  end

  // Entry lands in the cycle stb rises
  always_ff @(posedge clk) begin
    if (tlb && spr_bus_we_i && !stb_q) begin
      if (spr_bus_addr_i[7]) begin
        trans_sh[spr_set] <= spr_bus_dat_i;
      end else begin
        match_sh[spr_set] <= spr_bus_dat_i;
      end
    end
  end

  ////////////////////
  // Lookup model

  assign fetch_set = virt_addr_match_i[PAGE_BITS +: SET_WIDTH];
  assign m_ent = match_sh[fetch_set];
  assign t_ent = trans_sh[fetch_set];
  assign hit = m_ent[0] && (m_ent[31:13] == virt_addr_match_i[31:13]);

  // Stb-rise and first ack cycles of a TLB access
  assign busy_exp = enable_i && ((tlb && !stb_q) || rise_q);
  assign chk = enable_i && !busy_exp;

  // Physical address, cache inhibit, miss, fault
  assign look = {phys_addr_o, cache_inhibit_o, tlb_miss_o, pagefault_o};
  assign look_exp = hit ? {t_ent[31:13], virt_addr_match_i[12:0], t_ent[1], 1'b0,
                           supervisor_mode_i ? !t_ent[6] : !t_ent[7]}
                        : {8'h00, virt_addr_match_i[23:0], 3'b011};

  ////////////////////
  // Assertions

  // Never in the stb-rise cycle, never for another group
  a_ack_gate: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_o |-> grp && stb_q)
    else count_failure("acknowledge outside the cycle after a group 2 strobe rose");

  a_ack_next: assert property (@(posedge clk) disable iff (rst)
      grp && !stb_q |=> spr_bus_ack_o)
    else count_failure("acknowledge missing one cycle after a group 2 strobe rose");

  a_readback: assert property (@(posedge clk) disable iff (rst)
      spr_bus_ack_o && tlb && !spr_bus_we_i |-> spr_bus_dat_o == rd_exp)
    else count_failure($sformatf("mismatch spr_bus_dat_o %h expected %h",
                                 spr_bus_dat_o, rd_exp));

  a_lookup: assert property (@(posedge clk) disable iff (rst)
      chk |-> look == look_exp)
    else count_failure($sformatf(
      "mismatch {phys_addr_o, cache_inhibit_o, tlb_miss_o, pagefault_o} %h expected %h",
      look, look_exp));

  a_busy: assert property (@(posedge clk) disable iff (rst)
      busy_o == busy_exp)
    else count_failure($sformatf("mismatch busy_o %h expected %h", busy_o, busy_exp));

  // Lookup results are invalid here, but miss and fault must stay quiet
  a_busy_mask: assert property (@(posedge clk) disable iff (rst)
      busy_exp |-> !tlb_miss_o && !pagefault_o)
    else count_failure("miss or fault raised while an SPR access held the TLB");

endmodule

bind or1k_immu or1k_immu_sva #(
  .SET_WIDTH (SET_WIDTH)
) or1k_immu_sva_i (.*);

//--- tb/or1k_immu_tb.sv
`timescale 1ns/1ps

module or1k_immu_tb;
  import immu_pkg::*;

  localparam int SET_WIDTH = 6;
  localparam int SETS = 2 ** SET_WIDTH;
  // Whole sequence runs about 1800 cycles
  localparam int MAX_CYCLES = 4000;
  localparam int FETCHES = 400;
  // Group 2, TLB region, set field zero
  localparam spr_addr_t MATCH_BASE = 16'h1200;
  localparam spr_addr_t TRANS_BASE = 16'h1280;
  // Group 3, never answered
  localparam spr_addr_t OTHER_ADDR = 16'h1a00;

  logic      clk;
  logic      rst;
  logic      enable_i;
  logic      busy_o;
  word_t     virt_addr_i;
  word_t     virt_addr_match_i = '0;
  word_t     phys_addr_o;
  logic      cache_inhibit_o;
  logic      supervisor_mode_i;
  logic      tlb_miss_o;
  logic      pagefault_o;
  spr_addr_t spr_bus_addr_i;
  logic      spr_bus_we_i;
  logic      spr_bus_stb_i;
  word_t     spr_bus_dat_i;
  word_t     spr_bus_dat_o;
  logic      spr_bus_ack_o;

  // VPN last written per set, to build hit addresses
  vpn_t vpns [SETS];
  int   cycles = 0;

  or1k_immu #(
    .SET_WIDTH (SET_WIDTH)
  ) or1k_immu_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = !clk;
  end

  // Address under translation trails the fetch address by a cycle
  always @(posedge clk) begin
    virt_addr_match_i <= virt_addr_i;
  end

  task automatic report_and_finish(input logic timed_out);
    int errors;
    errors = or1k_immu_i.or1k_immu_sva_i.err_count;
    $display("Errors: %0d assertion failures, %0d timeouts", errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, test sequence did not finish", cycles);
      report_and_finish(1'b1);
    end
  end

  ////////////////////
  // SPR bus

  // Request held through one or two ack cycles then dropped for a cycle
  task automatic spr_access(input spr_addr_t addr, input logic we, input word_t dat);
    @(posedge clk);
    spr_bus_stb_i  <= 1'b1;
    spr_bus_we_i   <= we;
    spr_bus_addr_i <= addr;
    spr_bus_dat_i  <= dat;
    do begin
      @(negedge clk);
    end while (!spr_bus_ack_o);
    @(posedge clk);
    // Second ack cycle reads data from the hold register
    repeat (int'($urandom_range(1))) @(posedge clk);
    spr_bus_stb_i <= 1'b0;
  endtask

  // No ack expected, so stb is dropped after a fixed wait
  task automatic spr_unacked(input spr_addr_t addr);
    @(posedge clk);
    spr_bus_stb_i  <= 1'b1;
    spr_bus_we_i   <= 1'b0;
    spr_bus_addr_i <= addr;
    repeat (3) @(posedge clk);
    spr_bus_stb_i <= 1'b0;
  endtask

  // VPN low bits equal the set so a hit is reachable
  task automatic write_entry(input int set, input logic valid);
    vpn_t  vpn;
    word_t trans;
    vpn = {(VPN_WIDTH-SET_WIDTH)'($urandom), SET_WIDTH'(set)};
    // SXE and UXE follow the set, so all four combinations occur
    trans = {VPN_WIDTH'($urandom), 5'($urandom), 2'(set), 6'($urandom)};
    vpns[set] = vpn;
    spr_access(MATCH_BASE + spr_addr_t'(set), 1'b1, {vpn, 12'($urandom), valid});
    spr_access(TRANS_BASE + spr_addr_t'(set), 1'b1, trans);
  endtask

  task automatic read_entry(input int set);
    spr_access(MATCH_BASE + spr_addr_t'(set), 1'b0, '0);
    spr_access(TRANS_BASE + spr_addr_t'(set), 1'b0, '0);
  endtask

  ////////////////////
  // Fetch side

  // Miss by flipping the top VPN bit, index unchanged
  task automatic fetch(input int set, input logic hit);
    vpn_t vpn;
    vpn = hit ? vpns[set] : vpns[set] ^ (vpn_t'(1) << (VPN_WIDTH - 1));
    @(posedge clk);
    virt_addr_i       <= {vpn, PAGE_BITS'($urandom)};
    supervisor_mode_i <= 1'($urandom);
  endtask

  initial begin
    int set;
    void'($urandom(32'h1d1d));
    rst               = 1'b1;
    enable_i          = 1'b0;
    virt_addr_i       = '0;
    supervisor_mode_i = 1'b1;
    spr_bus_stb_i     = 1'b0;
    spr_bus_we_i      = 1'b0;
    spr_bus_addr_i    = '0;
    spr_bus_dat_i     = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // MMU off while every set is filled and read back
    for (int s = 0; s < SETS; s++) begin
      write_entry(s, 1'b1);
    end
    for (int s = 0; s < SETS; s++) begin
      read_entry(s);
    end

    @(posedge clk);
    enable_i <= 1'b1;
    // Mostly hits, with SPR traffic mixed in
    for (int i = 0; i < FETCHES; i++) begin
      fetch(int'($urandom_range(SETS - 1)), $urandom_range(3) != 0);
      if (i % 16 == 15) begin
        set = int'($urandom_range(SETS - 1));
        write_entry(set, 1'($urandom));
        read_entry(set);
        spr_unacked(OTHER_ADDR);
        fetch(set, 1'b1);
      end
    end
    repeat (4) @(posedge clk);
    report_and_finish(1'b0);
  end

endmodule

//--- or1k_immu.f
verilog/immu_pkg.sv
verilog/itlb_ram.sv
verilog/itlb_spr_port.sv
verilog/itlb_lookup.sv
verilog/or1k_immu.sv
tb/or1k_immu_sva.sv
tb/or1k_immu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module or1k_immu_tb -f or1k_immu.f

# Keep running past assertion failures so the closing lines are printed
./obj_dir/Vor1k_immu_tb +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
grep -q "STATUS: PASS" sim.log
